// ==== common/mpeg_pkg.sv ====
// stream byte type, start-code and segment constants, keystream step
package mpeg_pkg;

	typedef logic [7:0] byte_t;

	// prefix 00 00 01, then one stream ID byte
	localparam int START_PREFIX_LEN = 3;
	localparam int SEG_HEADER_LEN = 4;

	localparam byte_t PREFIX_ZERO = 8'h00;
	localparam byte_t PREFIX_ONE = 8'h01;

	localparam byte_t VID_ID_LO = 8'hE0;
	localparam byte_t VID_ID_HI = 8'hEF;

	// 8-bit Galois LFSR
	localparam byte_t LFSR_SEED = 8'hA5;
	localparam byte_t LFSR_TAPS = 8'hB8;

	function automatic logic is_video_id(input byte_t id);
		return (id >= VID_ID_LO) && (id <= VID_ID_HI);
	endfunction

	// shift right, fold the taps back in when a one drops out
	function automatic byte_t lfsr_next(input byte_t state);
		byte_t nxt;
		nxt = state >> 1;
		if (state[0]) begin
			nxt = nxt ^ LFSR_TAPS;
		end
		return nxt;
	endfunction

endpackage

// ==== common/pipe_pkg.sv ====
// order tag and tagged video byte types, default buffer sizes
package pipe_pkg;

	import mpeg_pkg::*;

	// one tag per released byte, replayed by the joiner
	typedef enum logic {
		route_misc = 1'b0,
		route_video = 1'b1
	} route_t;

	typedef struct packed {
		logic  seg_first;
		byte_t data;
	} vid_byte_t;

	localparam int DEF_VID_DEPTH = 64;
	localparam int DEF_MISC_DEPTH = 64;
	// order FIFO sees every byte of both paths
	localparam int DEF_ORDER_DEPTH = 128;
	localparam int DEF_AFULL_MARGIN = 6;

endpackage

// ==== hw/sync_fifo.sv ====
// single-clock FIFO with typed payload and almost-full flag
`timescale 1ns/1ps

module sync_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int DEPTH = 64,
	parameter int AFULL_MARGIN = 6
) (
	input  logic     clk,
	input  logic     rst_n,
	input  payload_t din,
	input  logic     wr,
	output payload_t dout,
	input  logic     rd,
	output logic     empty,
	output logic     almost_full
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);
	localparam logic [AW-1:0] LAST_PTR = AW'(DEPTH - 1);
	localparam logic [CW-1:0] FULL_LEVEL = CW'(DEPTH);
	// free entries at or below the margin
	localparam logic [CW-1:0] AFULL_LEVEL = CW'(DEPTH - AFULL_MARGIN);

	payload_t mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic do_wr;
	logic do_rd;

	// writes when full and reads when empty are dropped
	assign do_wr = wr && (count != FULL_LEVEL);
	assign do_rd = rd && !empty;

	assign empty = (count == '0);
	assign almost_full = (count >= AFULL_LEVEL);
	assign dout = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= din;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
			end
			case ({do_wr, do_rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// ==== splitter/start_code_splitter.sv ====
// start-code detection, three-byte hold window and per-byte routing
`timescale 1ns/1ps

module start_code_splitter
	import mpeg_pkg::*;
	import pipe_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  byte_t     in_data,
	input  logic      in_en,
	input  logic      stream_end,
	input  logic      vid_afull,
	input  logic      misc_afull,
	input  logic      order_afull,
	output vid_byte_t vid_data,
	output logic      vid_wr,
	output byte_t     misc_data,
	output logic      misc_wr,
	output route_t    order_tag,
	output logic      order_wr,
	output logic      prog_full
);

	localparam int W = START_PREFIX_LEN;

	// win[W-1] is the oldest held byte
	byte_t win [W];
	logic [W-1:0] vld;
	logic flushing;
	route_t cur_route;
	route_t id_route;
	route_t rel_route;
	logic prefix_hit;
	logic shift;
	logic rel;

	assign prefix_hit = in_en && (&vld) && (win[W-1] == PREFIX_ZERO) &&
		(win[W-2] == PREFIX_ZERO) && (win[0] == PREFIX_ONE);
	assign id_route = is_video_id(in_data) ? route_video : route_misc;
	// the released byte is the first 00 of a new prefix on a hit
	assign rel_route = prefix_hit ? id_route : cur_route;

	assign shift = in_en || (flushing && (|vld));
	assign rel = shift && vld[W-1];

	assign prog_full = vid_afull || misc_afull || order_afull;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			vld <= '0;
			flushing <= 1'b0;
			cur_route <= route_misc;
			vid_wr <= 1'b0;
			misc_wr <= 1'b0;
			order_wr <= 1'b0;
		end else begin
			vid_wr <= rel && (rel_route == route_video);
			misc_wr <= rel && (rel_route == route_misc);
			order_wr <= rel;
			if (shift) begin
				vld <= {vld[W-2:0], in_en};
			end
			if (prefix_hit) begin
				cur_route <= id_route;
			end
			if (stream_end) begin
				flushing <= 1'b1;
			end else if (flushing && (vld == '0)) begin
				// next stream starts outside any segment
				flushing <= 1'b0;
				cur_route <= route_misc;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (shift) begin
			win[0] <= in_data;
			for (int i = W - 1; i > 0; i--) begin
				win[i] <= win[i-1];
			end
		end
		if (rel) begin
			vid_data.data <= win[W-1];
			vid_data.seg_first <= prefix_hit && (id_route == route_video);
			misc_data <= win[W-1];
			order_tag <= rel_route;
		end
	end

endmodule

// ==== hw/payload_scrambler.sv ====
// keystream XOR of video payload bytes, restarted per segment
`timescale 1ns/1ps

module payload_scrambler
	import mpeg_pkg::*;
	import pipe_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  vid_byte_t in_data,
	input  logic      in_empty,
	output logic      in_rd,
	output byte_t     scr_data,
	output logic      scr_valid,
	input  logic      scr_take
);

	localparam int HW = $clog2(SEG_HEADER_LEN + 1);

	logic [HW-1:0] hdr_cnt;
	byte_t lfsr;
	logic pop;
	logic in_header;

	assign pop = !in_empty && (!scr_valid || scr_take);
	assign in_rd = pop;
	// prefix and stream ID pass through
	assign in_header = in_data.seg_first || (hdr_cnt < HW'(SEG_HEADER_LEN));

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			scr_valid <= 1'b0;
			hdr_cnt <= '0;
			lfsr <= LFSR_SEED;
		end else begin
			if (pop) begin
				scr_valid <= 1'b1;
			end else if (scr_take) begin
				scr_valid <= 1'b0;
			end
			if (pop) begin
				if (in_data.seg_first) begin
					hdr_cnt <= HW'(1);
					lfsr <= LFSR_SEED;
				end else if (in_header) begin
					hdr_cnt <= hdr_cnt + 1'b1;
				end else begin
					lfsr <= lfsr_next(lfsr);
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (pop) begin
			scr_data <= in_header ? in_data.data : (in_data.data ^ lfsr);
		end
	end

endmodule

// ==== hw/stream_joiner.sv ====
// order-driven merge of video and misc paths onto the output
`timescale 1ns/1ps

module stream_joiner
	import mpeg_pkg::*;
	import pipe_pkg::*;
(
	input  logic   clk,
	input  logic   rst_n,
	input  route_t order_tag,
	input  logic   order_empty,
	output logic   order_rd,
	input  byte_t  scr_data,
	input  logic   scr_valid,
	output logic   scr_take,
	input  byte_t  misc_data,
	input  logic   misc_empty,
	output logic   misc_rd,
	output byte_t  out_data,
	output logic   out_en
);

	logic want_video;
	logic path_ready;
	logic go;

	assign want_video = (order_tag == route_video);
	// wait on whichever path the head tag points at
	assign path_ready = want_video ? scr_valid : !misc_empty;
	assign go = !order_empty && path_ready;

	assign order_rd = go;
	assign scr_take = go && want_video;
	assign misc_rd = go && !want_video;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_en <= 1'b0;
		end else begin
			out_en <= go;
		end
	end

	always_ff @(posedge clk) begin
		if (go) begin
			out_data <= want_video ? scr_data : misc_data;
		end
	end

endmodule

// ==== hw/mpeg_stream_core.sv ====
// top level wiring the splitter, three FIFOs, payload scrambler and joiner
`timescale 1ns/1ps

module mpeg_stream_core
	import mpeg_pkg::*;
	import pipe_pkg::*;
#(
	parameter int VID_DEPTH = DEF_VID_DEPTH,
	parameter int MISC_DEPTH = DEF_MISC_DEPTH,
	parameter int ORDER_DEPTH = DEF_ORDER_DEPTH,
	parameter int AFULL_MARGIN = DEF_AFULL_MARGIN
) (
	input  logic  clk,
	input  logic  rst_n,
	input  byte_t mpeg_in,
	input  logic  mpeg_in_en,
	input  logic  stream_end,
	output byte_t mpeg_out,
	output logic  mpeg_out_en,
	output logic  mpeg_prog_full
);

	vid_byte_t vid_wr_data;
	vid_byte_t vid_head;
	logic vid_wr;
	logic vid_rd;
	logic vid_empty;
	logic vid_afull;

	byte_t misc_wr_data;
	byte_t misc_head;
	logic misc_wr;
	logic misc_rd;
	logic misc_empty;
	logic misc_afull;

	route_t order_wr_tag;
	route_t order_head;
	logic order_wr;
	logic order_rd;
	logic order_empty;
	logic order_afull;

	byte_t scr_data;
	logic scr_valid;
	logic scr_take;

	start_code_splitter u_splitter (
		.clk         (clk),
		.rst_n       (rst_n),
		.in_data     (mpeg_in),
		.in_en       (mpeg_in_en),
		.stream_end  (stream_end),
		.vid_afull   (vid_afull),
		.misc_afull  (misc_afull),
		.order_afull (order_afull),
		.vid_data    (vid_wr_data),
		.vid_wr      (vid_wr),
		.misc_data   (misc_wr_data),
		.misc_wr     (misc_wr),
		.order_tag   (order_wr_tag),
		.order_wr    (order_wr),
		.prog_full   (mpeg_prog_full)
	);

	sync_fifo #(
		.payload_t    (vid_byte_t),
		.DEPTH        (VID_DEPTH),
		.AFULL_MARGIN (AFULL_MARGIN)
	) u_vid_fifo (
		.clk         (clk),
		.rst_n       (rst_n),
		.din         (vid_wr_data),
		.wr          (vid_wr),
		.dout        (vid_head),
		.rd          (vid_rd),
		.empty       (vid_empty),
		.almost_full (vid_afull)
	);

	sync_fifo #(
		.payload_t    (byte_t),
		.DEPTH        (MISC_DEPTH),
		.AFULL_MARGIN (AFULL_MARGIN)
	) u_misc_fifo (
		.clk         (clk),
		.rst_n       (rst_n),
		.din         (misc_wr_data),
		.wr          (misc_wr),
		.dout        (misc_head),
		.rd          (misc_rd),
		.empty       (misc_empty),
		.almost_full (misc_afull)
	);

	sync_fifo #(
		.payload_t    (route_t),
		.DEPTH        (ORDER_DEPTH),
		.AFULL_MARGIN (AFULL_MARGIN)
	) u_order_fifo (
		.clk         (clk),
		.rst_n       (rst_n),
		.din         (order_wr_tag),
		.wr          (order_wr),
		.dout        (order_head),
		.rd          (order_rd),
		.empty       (order_empty),
		.almost_full (order_afull)
	);

	payload_scrambler u_scrambler (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_data   (vid_head),
		.in_empty  (vid_empty),
		.in_rd     (vid_rd),
		.scr_data  (scr_data),
		.scr_valid (scr_valid),
		.scr_take  (scr_take)
	);

	stream_joiner u_joiner (
		.clk         (clk),
		.rst_n       (rst_n),
		.order_tag   (order_head),
		.order_empty (order_empty),
		.order_rd    (order_rd),
		.scr_data    (scr_data),
		.scr_valid   (scr_valid),
		.scr_take    (scr_take),
		.misc_data   (misc_head),
		.misc_empty  (misc_empty),
		.misc_rd     (misc_rd),
		.out_data    (mpeg_out),
		.out_en      (mpeg_out_en)
	);

endmodule

// ==== sim/tb_mpeg_stream_core.sv ====
// mpeg_stream_core testbench with directed tests, stream model and compare tasks
`timescale 1ns/1ps

module tb_mpeg_stream_core
	import mpeg_pkg::*;
();

	logic clk;
	logic rst_n;
	byte_t mpeg_in;
	logic mpeg_in_en;
	logic stream_end;
	byte_t mpeg_out;
	logic mpeg_out_en;
	logic mpeg_prog_full;

	byte_t stim_q[$];
	byte_t exp_q[$];
	byte_t rx_q[$];
	int tests_run;
	int tests_failed;
	int mismatches;

	mpeg_stream_core u_dut (
		.clk            (clk),
		.rst_n          (rst_n),
		.mpeg_in        (mpeg_in),
		.mpeg_in_en     (mpeg_in_en),
		.stream_end     (stream_end),
		.mpeg_out       (mpeg_out),
		.mpeg_out_en    (mpeg_out_en),
		.mpeg_prog_full (mpeg_prog_full)
	);

	always #20 clk = ~clk;

	// output registers settle well before the falling edge
	always @(negedge clk) begin
		if (rst_n && mpeg_out_en) begin
			rx_q.push_back(mpeg_out);
		end
	end

	task automatic check_byte(input string name, input int idx, input byte_t exp_b,
			input byte_t act_b, output bit ok);
		ok = 1'b1;
		if (exp_b !== act_b) begin
			$display("Fail %s byte %0d: expected %02h, actual %02h", name, idx, exp_b, act_b);
			mismatches++;
			ok = 1'b0;
		end
	endtask

	task automatic check_count(input string name, input int exp_n, input int act_n,
			output bit ok);
		ok = 1'b1;
		if (exp_n != act_n) begin
			$display("Fail %s byte count: expected %0d, actual %0d", name, exp_n, act_n);
			mismatches++;
			ok = 1'b0;
		end
	endtask

	task automatic check_flag(input string name, input string what, input logic exp_v,
			input logic act_v, output bit ok);
		ok = 1'b1;
		if (exp_v !== act_v) begin
			$display("Fail %s %s: expected %0b, actual %0b", name, what, exp_v, act_v);
			mismatches++;
			ok = 1'b0;
		end
	endtask

	// expected stream keeps the input order with video payload XORed by the keystream
	function automatic void build_expected();
		byte_t key;
		bit video;
		int off;
		int n;
		exp_q.delete();
		video = 1'b0;
		off = 0;
		key = LFSR_SEED;
		n = stim_q.size();
		for (int i = 0; i < n; i++) begin
			if ((i + 3 < n) && stim_q[i] == 8'h00 && stim_q[i+1] == 8'h00 &&
					stim_q[i+2] == 8'h01) begin
				video = (stim_q[i+3] >= VID_ID_LO) && (stim_q[i+3] <= VID_ID_HI);
				off = 0;
				key = LFSR_SEED;
			end
			if (video && off >= SEG_HEADER_LEN) begin
				exp_q.push_back(stim_q[i] ^ key);
				key = (key >> 1) ^ (key[0] ? LFSR_TAPS : 8'h00);
			end else begin
				exp_q.push_back(stim_q[i]);
			end
			off++;
		end
	endfunction

	task automatic push_segment(input byte_t id, input int len, input int base);
		stim_q.push_back(8'h00);
		stim_q.push_back(8'h00);
		stim_q.push_back(8'h01);
		stim_q.push_back(id);
		for (int k = 0; k < len; k++) begin
			stim_q.push_back(byte_t'(base + 13 * k));
		end
	endtask

	task automatic drive_stream(input int gap_pct, output bit ok);
		int stall;
		ok = 1'b1;
		for (int i = 0; i < stim_q.size(); i++) begin
			if ($urandom_range(99) < gap_pct) begin
				@(posedge clk);
				mpeg_in_en <= 1'b0;
			end
			stall = 0;
			while (mpeg_prog_full && stall < 2000) begin
				@(posedge clk);
				mpeg_in_en <= 1'b0;
				stall++;
			end
			if (mpeg_prog_full) begin
				$display("input held off by mpeg_prog_full for too long at byte %0d", i);
				ok = 1'b0;
			end
			@(posedge clk);
			mpeg_in <= stim_q[i];
			mpeg_in_en <= 1'b1;
		end
		@(posedge clk);
		mpeg_in_en <= 1'b0;
		stream_end <= 1'b1;
		@(posedge clk);
		stream_end <= 1'b0;
	endtask

	task automatic run_stream(input string name, input int gap_pct);
		int limit;
		int waited;
		int n;
		bit ok;
		bit good;
		bit same;
		build_expected();
		rx_q.delete();
		drive_stream(gap_pct, ok);
		limit = 20 * exp_q.size() + 200;
		waited = 0;
		while (rx_q.size() < exp_q.size() && waited < limit) begin
			@(posedge clk);
			waited++;
		end
		if (rx_q.size() < exp_q.size()) begin
			$display("%s timed out after %0d cycles with %0d of %0d bytes out", name, waited,
				rx_q.size(), exp_q.size());
			ok = 1'b0;
		end
		check_count(name, exp_q.size(), rx_q.size(), good);
		if (!good) begin
			ok = 1'b0;
		end
		// all FIFOs are drained once the last byte is out
		check_flag(name, "mpeg_prog_full", 1'b0, mpeg_prog_full, good);
		if (!good) begin
			ok = 1'b0;
		end
		n = (rx_q.size() < exp_q.size()) ? rx_q.size() : exp_q.size();
		same = 1'b1;
		// stop at the first wrong byte since later ones are usually shifted
		for (int i = 0; i < n && same; i++) begin
			check_byte(name, i, exp_q[i], rx_q[i], same);
		end
		tests_run++;
		if (ok && same) begin
			$display("test %s: ok, %0d bytes", name, rx_q.size());
		end else begin
			tests_failed++;
			$display("test %s: failed", name);
		end
	endtask

	task automatic test_reset_state();
		bit out_ok;
		bit full_ok;
		check_flag("reset_state", "mpeg_out_en", 1'b0, mpeg_out_en, out_ok);
		check_flag("reset_state", "mpeg_prog_full", 1'b0, mpeg_prog_full, full_ok);
		tests_run++;
		if (out_ok && full_ok) begin
			$display("test reset_state: ok");
		end else begin
			tests_failed++;
			$display("test reset_state: failed");
		end
	endtask

	task automatic test_misc_only();
		stim_q.delete();
		stim_q.push_back(8'h11);
		stim_q.push_back(8'h22);
		stim_q.push_back(8'h33);
		stim_q.push_back(8'h44);
		push_segment(8'hC0, 6, 8'h20);
		push_segment(8'hC0, 4, 8'h70);
		run_stream("misc_only", 0);
	endtask

	task automatic test_single_video();
		stim_q.delete();
		push_segment(8'hE0, 12, 8'h05);
		run_stream("single_video", 0);
	endtask

	task automatic test_alternating();
		stim_q.delete();
		push_segment(8'hE0, 6, 8'h10);
		push_segment(8'hC0, 4, 8'h80);
		push_segment(8'hE7, 8, 8'h30);
		push_segment(8'hC2, 3, 8'h90);
		run_stream("alternating", 0);
	endtask

	// trailing 00 00 is still held in the window at stream_end
	task automatic test_partial_prefix();
		stim_q.delete();
		push_segment(8'hE0, 5, 8'h40);
		stim_q.push_back(8'h00);
		stim_q.push_back(8'h00);
		run_stream("partial_prefix", 0);
	endtask

	task automatic test_random_mixed();
		byte_t id;
		int len;
		stim_q.delete();
		while (stim_q.size() < 400) begin
			if ($urandom_range(1) == 1) begin
				id = VID_ID_LO + byte_t'($urandom_range(15));
			end else begin
				id = 8'hC0 + byte_t'($urandom_range(15));
			end
			len = $urandom_range(40, 5);
			stim_q.push_back(8'h00);
			stim_q.push_back(8'h00);
			stim_q.push_back(8'h01);
			stim_q.push_back(id);
			for (int k = 0; k < len; k++) begin
				stim_q.push_back(byte_t'($urandom_range(255)));
			end
		end
		while (stim_q.size() > 400) begin
			void'(stim_q.pop_back());
		end
		run_stream("random_mixed", 30);
	endtask

	initial begin
		void'($urandom(4));
		clk = 1'b0;
		rst_n = 1'b0;
		mpeg_in = '0;
		mpeg_in_en = 1'b0;
		stream_end = 1'b0;
		tests_run = 0;
		tests_failed = 0;
		mismatches = 0;
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		test_reset_state();
		test_misc_only();
		test_single_video();
		test_alternating();
		test_partial_prefix();
		test_random_mixed();
		$display("tests run: %0d, failed: %0d, mismatches: %0d", tests_run, tests_failed,
			mismatches);
		if (tests_failed == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

// ==== tb.f ====
common/mpeg_pkg.sv
common/pipe_pkg.sv
hw/sync_fifo.sv
splitter/start_code_splitter.sv
hw/payload_scrambler.sv
hw/stream_joiner.sv
hw/mpeg_stream_core.sv
sim/tb_mpeg_stream_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the testbench with Verilator, then scan the log

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --top-module tb_mpeg_stream_core -f tb.f -o tb_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "build failed"
	exit 1
fi

./obj_dir/tb_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Errors found" "$log"; then
	exit 1
fi
exit 0
